/* hw/cpu_config.svh */
// Core sizing and NOP encoding; depths must stay powers of two because addresses are truncated
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Architectural register count, indexed by a 3-bit select
`define CPU_NUM_REGS 8

// Data memory depth in 16-bit words
`define CPU_DMEM_WORDS 16

// Opcode 00001 with every other field zero
`define CPU_NOP_INSTR 16'h0800

`endif

/* hw/cpu_pkg.sv */
// Types shared by all stages; only the opcodes listed here are decoded, all others act as NOP
package cpu_pkg;

  typedef logic [15:0] word_t;   // Data and instruction word
  typedef logic [2:0]  regSel_t; // Register index
  typedef logic [4:0]  opcode_t; // Instruction bits 15:11

  localparam opcode_t OP_HALT  = 5'b00000;
  localparam opcode_t OP_NOP   = 5'b00001;
  localparam opcode_t OP_ADDI  = 5'b01000;
  localparam opcode_t OP_SUBI  = 5'b01001;
  localparam opcode_t OP_XORI  = 5'b01010;
  localparam opcode_t OP_ANDNI = 5'b01011;
  localparam opcode_t OP_ST    = 5'b10000;
  localparam opcode_t OP_LD    = 5'b10001;
  localparam opcode_t OP_SLBI  = 5'b10010;
  localparam opcode_t OP_LBI   = 5'b11000;
  localparam opcode_t OP_ALU   = 5'b11011; // R-format, func in bits 1:0

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUBR,  // B minus A
    ALU_XOR,
    ALU_ANDN,  // A and not B
    ALU_PASSB,
    ALU_SLBI
  } aluOp_t;

  typedef struct packed {
    logic    valid;
    regSel_t rs;
    regSel_t rt;
    word_t   rsVal;
    word_t   rtVal;
    word_t   imm;
    logic    immSel;
    aluOp_t  aluOp;
    logic    memEn;
    logic    memWrt;
    logic    regWrt;
    regSel_t dest;
    logic    halt;
  } decodeBundle_t;

  typedef struct packed {
    logic    valid;
    word_t   result;    // ALU value or memory address
    word_t   storeData;
    logic    memEn;
    logic    memWrt;
    logic    regWrt;
    regSel_t dest;
    logic    halt;
  } execBundle_t;

  // valid marks a register write this cycle; halt stays set once reached
  typedef struct packed {
    logic    valid;
    logic    regWrt;
    regSel_t dest;
    word_t   data;
    logic    halt;
  } wbBundle_t;

endpackage

/* hw/instrDecoder.sv */
// Purely combinational; undefined opcodes and R-format funcs decode as a NOP with no side effects
module instrDecoder (
  input  cpu_pkg::opcode_t opcode,
  input  logic [1:0]       func,
  output cpu_pkg::aluOp_t  aluOp,
  output logic             immSel,
  output logic             zeroExt,
  output logic             useImm8,
  output logic [1:0]       regDst,
  output logic             regWrt,
  output logic             memEn,
  output logic             memWrt,
  output logic             halt
);
  import cpu_pkg::*;

  always_comb begin
    aluOp   = ALU_ADD; // NOP defaults
    immSel  = 1'b0;
    zeroExt = 1'b0;
    useImm8 = 1'b0;
    regDst  = 2'd0;
    regWrt  = 1'b0;
    memEn   = 1'b0;
    memWrt  = 1'b0;
    halt    = 1'b0;
    case (opcode)
      OP_HALT: halt = 1'b1;
      OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
        immSel  = 1'b1;
        regDst  = 2'd1;          // Rd in bits 7:5
        regWrt  = 1'b1;
        zeroExt = opcode[1];     // XORI and ANDNI zero extend
        aluOp   = aluOp_t'({1'b0, opcode[1:0]});
      end
      OP_ALU: begin
        regDst = 2'd2;           // Rd in bits 4:2
        regWrt = 1'b1;
        aluOp  = aluOp_t'({1'b0, func});
      end
      OP_LBI: begin
        aluOp   = ALU_PASSB;
        immSel  = 1'b1;
        useImm8 = 1'b1;
        regWrt  = 1'b1;
      end
      OP_SLBI: begin
        aluOp   = ALU_SLBI;
        immSel  = 1'b1;
        useImm8 = 1'b1;
        zeroExt = 1'b1;
        regWrt  = 1'b1;
      end
      OP_ST: begin
        immSel = 1'b1;           // Address is Rs plus imm5
        memEn  = 1'b1;
        memWrt = 1'b1;
      end
      OP_LD: begin
        immSel = 1'b1;
        memEn  = 1'b1;
        regDst = 2'd1;
        regWrt = 1'b1;
      end
      default: ;                 // NOP and unsupported opcodes
    endcase
  end

endmodule

/* hw/regFileBypass.sv */
// Two read ports, one write port; reads return the value being written in the same cycle
`include "cpu_config.svh"

module regFileBypass (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::regSel_t rdSel1,
  input  cpu_pkg::regSel_t rdSel2,
  input  cpu_pkg::regSel_t wrSel,
  input  cpu_pkg::word_t   wrData,
  input  logic             wrEn,
  output cpu_pkg::word_t   rdData1,
  output cpu_pkg::word_t   rdData2
);
  import cpu_pkg::*;

  word_t regs [`CPU_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;           // Architectural state reads zero
      end
    end else if (wrEn) begin
      regs[wrSel] <= wrData;
    end
  end

  // Write-before-read bypass
  assign rdData1 = (wrEn && (wrSel == rdSel1)) ? wrData : regs[rdSel1];
  assign rdData2 = (wrEn && (wrSel == rdSel2)) ? wrData : regs[rdSel2];

endmodule

/* hw/decodeStage.sv */
// Stall check compares both bits 10:8 and 7:5 even when a format ignores one; inputs stop after HALT
`include "cpu_config.svh"

module decodeStage (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_pkg::word_t         instr,
  input  logic                   instrValid,
  input  cpu_pkg::wbBundle_t     wb,
  input  logic                   halted,
  output logic                   fetchStall,
  output cpu_pkg::decodeBundle_t dx
);
  import cpu_pkg::*;

  word_t         ir;
  logic          irValid;
  logic          haltIssued;
  logic          stopped;
  logic          exLoad;
  logic          issue;
  word_t         curInstr;
  word_t         imm5Ext;
  word_t         imm8Ext;
  aluOp_t        aluOp;
  logic          immSel, zeroExt, useImm8, regWrt, memEn, memWrt, halt;
  logic [1:0]    regDst;
  regSel_t       dest;
  word_t         rsVal, rtVal;
  decodeBundle_t dxNext;

  assign curInstr = irValid ? ir : `CPU_NOP_INSTR; // Empty slot decodes as NOP
  assign stopped  = halted | haltIssued;
  assign exLoad   = dx.valid & dx.memEn & ~dx.memWrt;

  // Load-use hazard against the instruction now in execute
  assign fetchStall = irValid & exLoad &
                      ((dx.dest == curInstr[10:8]) | (dx.dest == curInstr[7:5]));
  assign issue = irValid & ~fetchStall & ~stopped;

  instrDecoder decoder_i (
    .opcode (curInstr[15:11]), .func   (curInstr[1:0]), .aluOp  (aluOp),
    .immSel (immSel),          .zeroExt(zeroExt),       .useImm8(useImm8),
    .regDst (regDst),          .regWrt (regWrt),        .memEn  (memEn),
    .memWrt (memWrt),          .halt   (halt)
  );

  regFileBypass regFile_i (
    .clk    (clk),           .rst    (rst),
    .rdSel1 (curInstr[10:8]), .rdSel2 (curInstr[7:5]),
    .wrSel  (wb.dest),        .wrData (wb.data),        .wrEn(wb.valid & wb.regWrt),
    .rdData1(rsVal),          .rdData2(rtVal)
  );

  assign imm5Ext = zeroExt ? {11'b0, curInstr[4:0]} : {{11{curInstr[4]}}, curInstr[4:0]};
  assign imm8Ext = zeroExt ? {8'b0, curInstr[7:0]}  : {{8{curInstr[7]}}, curInstr[7:0]};

  always_comb begin
    case (regDst)
      2'd0:    dest = curInstr[10:8];
      2'd1:    dest = curInstr[7:5];
      2'd2:    dest = curInstr[4:2];
      default: dest = 3'd7;
    endcase
  end

  assign dxNext = '{valid: issue, rs: curInstr[10:8], rt: curInstr[7:5],
                    rsVal: rsVal, rtVal: rtVal, imm: useImm8 ? imm8Ext : imm5Ext,
                    immSel: immSel, aluOp: aluOp, memEn: memEn, memWrt: memWrt,
                    regWrt: regWrt, dest: dest, halt: halt};

  always_ff @(posedge clk) begin
    if (rst) begin
      irValid    <= 1'b0;
      haltIssued <= 1'b0;
      dx.valid   <= 1'b0;
    end else begin
      if (!fetchStall) irValid <= instrValid & ~stopped; // Hold on stall
      if (issue && halt) haltIssued <= 1'b1;
      dx <= dxNext;                                      // Bubble when not issuing
    end
  end

  always_ff @(posedge clk) begin
    if (!fetchStall) ir <= instr;
  end

endmodule

/* hw/executeStage.sv */
// Forwarding from memory never sees a load result there; decode stalls that case one cycle
module executeStage (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_pkg::decodeBundle_t dx,
  input  cpu_pkg::wbBundle_t     wb,
  output cpu_pkg::execBundle_t   xm
);
  import cpu_pkg::*;

  word_t       opA;
  word_t       opB;
  word_t       aluB;
  word_t       result;
  execBundle_t xmNext;

  // Youngest producer wins
  always_comb begin
    if (xm.valid && xm.regWrt && (xm.dest == dx.rs)) begin
      opA = xm.result;
    end else if (wb.valid && wb.regWrt && (wb.dest == dx.rs)) begin
      opA = wb.data;
    end else begin
      opA = dx.rsVal;
    end
    if (xm.valid && xm.regWrt && (xm.dest == dx.rt)) begin
      opB = xm.result;
    end else if (wb.valid && wb.regWrt && (wb.dest == dx.rt)) begin
      opB = wb.data;
    end else begin
      opB = dx.rtVal;
    end
  end

  assign aluB = dx.immSel ? dx.imm : opB;

  always_comb begin
    case (dx.aluOp)
      ALU_ADD:   result = opA + aluB;        // Also LD/ST address
      ALU_SUBR:  result = aluB - opA;
      ALU_XOR:   result = opA ^ aluB;
      ALU_ANDN:  result = opA & ~aluB;
      ALU_PASSB: result = aluB;              // LBI
      ALU_SLBI:  result = {opA[7:0], 8'h00} | aluB;
      default:   result = '0;
    endcase
  end

  assign xmNext = '{valid: dx.valid, result: result, storeData: opB,
                    memEn: dx.memEn, memWrt: dx.memWrt, regWrt: dx.regWrt,
                    dest: dx.dest, halt: dx.halt};

  always_ff @(posedge clk) begin
    if (rst) begin
      xm.valid <= 1'b0;
    end else begin
      xm <= xmNext;
    end
  end

endmodule

/* hw/memStage.sv */
// Address wraps on the low result bits; the memory clears on reset like the registers
`include "cpu_config.svh"

module memStage (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_pkg::execBundle_t xm,
  output cpu_pkg::wbBundle_t   mw
);
  import cpu_pkg::*;

  localparam int AddrBits = $clog2(`CPU_DMEM_WORDS);

  word_t               mem [`CPU_DMEM_WORDS];
  logic [AddrBits-1:0] addr;
  word_t               loadData;
  logic                isLoad;

  assign addr     = xm.result[AddrBits-1:0];
  assign loadData = mem[addr];
  assign isLoad   = xm.memEn & ~xm.memWrt;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (xm.valid && xm.memEn && xm.memWrt) begin
      mem[addr] <= xm.storeData; // ST
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mw.valid <= 1'b0;
      mw.halt  <= 1'b0;
    end else begin
      mw.valid <= xm.valid & xm.regWrt;          // Only register writes complete here
      mw.halt  <= mw.halt | (xm.valid & xm.halt); // Sticky until reset
    end
  end

  // Writeback payload
  always_ff @(posedge clk) begin
    mw.regWrt <= xm.regWrt;
    mw.dest   <= xm.dest;
    mw.data   <= isLoad ? loadData : xm.result;
  end

endmodule

/* hw/cpuCore.sv */
// Instructions come in as words with a valid level; fetchStall high means the word is not taken
module cpuCore (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::word_t   instr,
  input  logic             instrValid,
  output logic             fetchStall,
  output logic             wbValid,
  output cpu_pkg::regSel_t wbReg,
  output cpu_pkg::word_t   wbData,
  output logic             halted
);
  import cpu_pkg::*;

  decodeBundle_t dx; // Decode to execute
  execBundle_t   xm; // Execute to memory
  wbBundle_t     mw; // Memory to writeback

  decodeStage decode_i (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .instrValid(instrValid),
    .wb        (mw),
    .halted    (halted),
    .fetchStall(fetchStall),
    .dx        (dx)
  );

  executeStage execute_i (
    .clk(clk),
    .rst(rst),
    .dx (dx),
    .wb (mw),
    .xm (xm)
  );

  memStage mem_i (
    .clk(clk),
    .rst(rst),
    .xm (xm),
    .mw (mw)
  );

  assign wbValid = mw.valid;
  assign wbReg   = mw.dest;
  assign wbData  = mw.data;
  assign halted  = mw.halt;

endmodule

/* tb/cpuCore_assert.sv */
// Sees only the core ports; a stall must last one cycle since a bubble always trails a load
module cpuCore_assert (
  input logic clk,
  input logic rst,
  input logic fetchStall,
  input logic wbValid,
  input logic halted
);

  int failCount = 0; // Failed assertions so far

  stallOneCycle: assert property (@(posedge clk) disable iff (rst) fetchStall |=> !fetchStall)
    else begin
      $error("fetchStall stayed high for two consecutive cycles");
      failCount++;
    end

  // Covers every reset cycle after the first and the cycle after release
  noWbInReset: assert property (@(posedge clk) rst |=> !wbValid)
    else begin
      $error("wbValid was high during or right after reset");
      failCount++;
    end

  haltSticky: assert property (@(posedge clk) (halted && !rst) |=> halted)
    else begin
      $error("halted fell without a reset");
      failCount++;
    end

endmodule

bind cpuCore cpuCore_assert assertChk_i (
  .clk       (clk),
  .rst       (rst),
  .fetchStall(fetchStall),
  .wbValid   (wbValid),
  .halted    (halted)
);

/* tb/cpuCore_tb.sv */
// Words go straight into the core with no fetch unit; all expected values were worked out by hand
`include "cpu_config.svh"

module cpuCore_tb;
  import cpu_pkg::*;

  localparam int StallLimit = 20; // Cycles per wait on fetchStall
  localparam int DrainLimit = 60; // Cycles for halted and the last writeback

  typedef struct {
    string   name;
    word_t   instr;
    bit      writes;
    regSel_t dest;
    word_t   data;
    bit      tight; // No idle gap before this row
  } testRow_t;

  logic        clk;
  logic        rst;
  word_t       instr;
  logic        instrValid;
  logic        fetchStall;
  logic        wbValid;
  regSel_t     wbReg;
  word_t       wbData;
  logic        halted;
  testRow_t    rows[$];
  int          expRows[$]; // Rows that write a register, in program order
  int          expIdx;
  int          checks;
  int          valueErrors;
  int          otherErrors;
  int          assertErrors;
  int          stallCycles;
  int unsigned seed;

  cpuCore dut_i (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .instrValid(instrValid),
    .fetchStall(fetchStall),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .wbData    (wbData),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic addRow(input string name, input word_t w, input bit writes,
                        input regSel_t dest, input word_t data, input bit tight);
    testRow_t r;
    r.name   = name;
    r.instr  = w;
    r.writes = writes;
    r.dest   = dest;
    r.data   = data;
    r.tight  = tight;
    if (writes) expRows.push_back(rows.size());
    rows.push_back(r);
  endtask

  task automatic buildTable();
    // name, word, writes, dest, data, tight
    addRow("lbi r1 0x12",        16'hC112, 1, 3'd1, 16'h0012, 0);
    addRow("slbi r1 0x34",       16'h9134, 1, 3'd1, 16'h1234, 1); // Forward from memory stage
    addRow("lbi r2 0x80",        16'hC280, 1, 3'd2, 16'hFF80, 0); // Sign extended
    addRow("lbi r3 0x05",        16'hC305, 1, 3'd3, 16'h0005, 0);
    addRow("addi r4 r3 -2",      16'h439E, 1, 3'd4, 16'h0003, 1);
    addRow("subi r5 r3 -1",      16'h4BBF, 1, 3'd5, 16'hFFFA, 1); // imm minus Rs
    addRow("xori r6 r2 0x1f",    16'h52DF, 1, 3'd6, 16'hFF9F, 0); // Zero extended
    addRow("andni r7 r1 0x14",   16'h59F4, 1, 3'd7, 16'h1220, 0);
    addRow("add r1 r3 r4",       16'hDB84, 1, 3'd1, 16'h0008, 0);
    addRow("sub r2 r1 r3",       16'hD969, 1, 3'd2, 16'hFFFD, 1); // Rt minus Rs
    addRow("xor r3 r2 r1",       16'hDA2E, 1, 3'd3, 16'hFFF5, 1);
    addRow("andn r4 r3 r5",      16'hDBB3, 1, 3'd4, 16'h0005, 1);
    addRow("st r7 to r0+3",      16'h80E3, 0, 3'd0, 16'h0000, 0);
    addRow("nop",                `CPU_NOP_INSTR, 0, 3'd0, 16'h0000, 0);
    addRow("ld r5 from r0+3",    16'h88A3, 1, 3'd5, 16'h1220, 0);
    addRow("add r6 r5 r4 after ld", 16'hDD98, 1, 3'd6, 16'h1225, 1); // Load-use stall
    addRow("halt",               16'h0000, 0, 3'd0, 16'h0000, 0);
    addRow("lbi r1 after halt",  16'hC155, 0, 3'd0, 16'h0000, 1);
    addRow("addi r2 after halt", 16'h4141, 0, 3'd0, 16'h0000, 0);
  endtask

  task automatic idleGap(input int n);
    instrValid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  // Returns just after the edge that takes the word
  task automatic issueWord(input word_t w, input string name);
    int waits;
    instr      <= w;
    instrValid <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (fetchStall && waits < StallLimit) begin
      waits++;
      @(negedge clk);
    end
    if (fetchStall) begin
      $display("Timeout: fetchStall stayed high while offering %s", name);
      otherErrors++;
    end
    @(posedge clk);
  endtask

  task automatic checkWriteback();
    testRow_t r;
    checks++;
    assert (expIdx < expRows.size()) else begin
      $display("Unexpected writeback to r%0d with data %h", wbReg, wbData);
      otherErrors++;
    end
    if (expIdx < expRows.size()) begin
      r = rows[expRows[expIdx]];
      assert (wbReg === r.dest) else begin
        $display("FAIL %s: expected dest r%0d, actual r%0d", r.name, r.dest, wbReg);
        valueErrors++;
      end
      assert (wbData === r.data) else begin
        $display("FAIL %s: expected data %h, actual %h", r.name, r.data, wbData);
        valueErrors++;
      end
      expIdx++;
    end
  endtask

  // Outputs are registered, so mid-cycle is a quiet point
  always @(negedge clk) begin
    if (!rst && fetchStall) stallCycles++;
    if (!rst && wbValid) checkWriteback();
  end

  initial begin
    int waits;
    rst          = 1'b1;
    instr        = `CPU_NOP_INSTR;
    instrValid   = 1'b0;
    expIdx       = 0;
    checks       = 0;
    valueErrors  = 0;
    otherErrors  = 0;
    assertErrors = 0;
    stallCycles  = 0;
    seed         = 70;
    void'($urandom(seed));
    buildTable();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    foreach (rows[i]) begin
      if (!rows[i].tight) idleGap(int'($urandom % 3));
      issueWord(rows[i].instr, rows[i].name);
    end
    instrValid <= 1'b0;
    waits = 0;
    @(negedge clk);
    while (!halted && waits < DrainLimit) begin
      waits++;
      @(negedge clk);
    end
    checks++;
    assert (halted) else begin
      $display("Timeout: halted never rose after HALT");
      otherErrors++;
    end
    waits = 0;
    while (expIdx < expRows.size() && waits < DrainLimit) begin
      waits++;
      @(posedge clk);
    end
    checks++;
    assert (expIdx == expRows.size()) else begin
      $display("Missing writebacks: saw %0d of %0d", expIdx, expRows.size());
      otherErrors++;
    end
    repeat (10) @(posedge clk); // Late or stray writebacks land in the checker
    @(negedge clk);
    checks += 2;
    assert (halted) else begin
      $display("halted dropped after it had risen");
      otherErrors++;
    end
    assert (stallCycles > 0) else begin
      $display("fetchStall never rose for the load followed by its user");
      otherErrors++;
    end
    assertErrors = dut_i.assertChk_i.failCount;
    $display("Summary: %0d checks, %0d value errors, %0d other errors, %0d assertion failures",
             checks, valueErrors, otherErrors, assertErrors);
    if (valueErrors + otherErrors + assertErrors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* cpuCore.f */
+incdir+hw
hw/cpu_pkg.sv
hw/instrDecoder.sv
hw/regFileBypass.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memStage.sv
hw/cpuCore.sv
tb/cpuCore_assert.sv
tb/cpuCore_tb.sv

/* Bender.yml */
package:
  name: cpucore

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_pkg.sv
      - hw/instrDecoder.sv
      - hw/regFileBypass.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/memStage.sv
      - hw/cpuCore.sv
      - target: test
        include_dirs:
          - hw
        files:
          - tb/cpuCore_assert.sv
          - tb/cpuCore_tb.sv
